// File: design/pr_pkg.sv
// Register unit package: word and field types, R0 flag positions, KI select codes, jumpers
package pr_pkg;

	// Bus word, big-endian numbering
	typedef logic [0:15] word_t;	// W, L, RZ, ZP, KI, RB

	typedef logic [0:2] reg_addr_t;	// 0 is R0, 1..7 are R1..R7
	typedef logic [0:8] flags_t;	// ZMVCLEGYX, R0 bits 0..8
	typedef logic [0:3] nb_t;	// Memory block number
	typedef logic [0:9] rs_t;	// RS field of the status word

	// KI bus source select, {kia, kib}
	typedef logic [1:0] ki_sel_t;
	localparam ki_sel_t KI_RZ = 2'd0;
	localparam ki_sel_t KI_SR = 2'd1;	// Status word
	localparam ki_sel_t KI_RB = 2'd2;
	localparam ki_sel_t KI_ZP = 2'd3;

	// L bus source
	typedef enum logic [1:0] {
		L_USER,	// Addressed R1..R7
		L_R0,	// R0 in place
		L_R0_HI	// R0 upper byte moved to bits 8..15
	} l_sel_t;

	// Flag positions within R0
	localparam int FLAG_Z = 0;	// Zero
	localparam int FLAG_M = 1;	// Minus
	localparam int FLAG_V = 2;	// Overflow
	localparam int FLAG_C = 3;	// Carry
	localparam int FLAG_L = 4;	// Less
	localparam int FLAG_E = 5;	// Equal
	localparam int FLAG_G = 6;	// Greater
	localparam int FLAG_Y = 7;
	localparam int FLAG_X = 8;

	// Board jumpers
	localparam logic CPU_NUMBER = 1'b0;	// CPU 0 position
	localparam logic AWP_PRESENT = 1'b1;	// Arithmetic co-processor fitted

endpackage

// File: design/pr_ctrl.sv
// Register unit control decode: strobe phases, write enables, L bus source select
`timescale 1ns/1ps

module pr_ctrl import pr_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      strob1,
	input  logic      strob2,
	input  logic      as2,	// Selects strobe phase
	input  logic      w_r,	// W bus to register
	input  logic      lpc,	// LPC instruction
	input  logic      rpc,	// RPC instruction
	input  logic      wa,	// State WA
	input  logic      blr,	// Block registers, R0 high byte on L
	input  logic      ustr0_fp,
	input  logic      ust_leg,
	input  reg_addr_t addr,
	input  logic      q,	// System flag, 1 is user mode
	output logic      ureg_we,
	output logic      r0_ld_all,
	output logic      r0_ld_low,
	output logic      r0_ld_zmvc,
	output logic      leg_upd,
	output l_sel_t    l_sel
);

	logic strob_a;
	logic strob_b;
	logic strob_b_raw;
	logic last_a;	// strob_a seen last cycle
	logic any_wr;
	logic addr_r0;

	assign strob_a = strob1 & ~as2;
	assign strob_b_raw = strob2 & as2;

	// A strob_b directly behind a strob_a is the tail of the same access
	always_ff @(posedge clk) begin
		if (rst) begin
			last_a <= 1'b0;
		end else begin
			last_a <= strob_a;
		end
	end

	assign strob_b = strob_b_raw & ~last_a;

	assign addr_r0 = (addr == reg_addr_t'(0));
	assign any_wr = w_r & (strob_a | strob_b);	// Register write in either phase

	assign ureg_we = any_wr & ~addr_r0;

	// System mode writes the whole of R0, user mode only bits 8..15
	assign r0_ld_all = (lpc & strob_a) | (any_wr & addr_r0 & ~q);
	assign r0_ld_low = any_wr & addr_r0 & q;

	assign r0_ld_zmvc = AWP_PRESENT & ustr0_fp & strob_a;	// From co-processor
	assign leg_upd = strob2 & ust_leg;

	// L bus source, blr wins
	always_comb begin
		if (blr) begin
			l_sel = L_R0_HI;
		end else if (addr_r0 || (rpc && wa)) begin
			l_sel = L_R0;
		end else begin
			l_sel = L_USER;
		end
	end

endmodule

// File: design/pr_user_regs.sv
// User register file R1..R7 with synchronous write and asynchronous read
`timescale 1ns/1ps

module pr_user_regs import pr_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      we,
	input  reg_addr_t addr,
	input  word_t     w,
	output word_t     rd
);

	word_t mem [1:7];	// R1..R7, no storage behind R0

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i <= 7; i++) begin
				mem[i] <= '0;
			end
		end else if (we && addr != reg_addr_t'(0)) begin
			mem[addr] <= w;
		end
	end

	// Address 0 reads zero, R0 lives elsewhere
	always_comb begin
		if (addr == reg_addr_t'(0)) begin
			rd = '0;
		end else begin
			rd = mem[addr];
		end
	end

endmodule

// File: design/pr_r0_flags.sv
// R0 register with CPU flags ZMVCLEGYX, grouped W loads and ALU flag updates
`timescale 1ns/1ps

module pr_r0_flags import pr_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  zer,	// Clears R0
	input  logic  strob1,	// ALU flag update phase
	input  word_t w,
	input  logic  ld_all,	// Bits 0..15
	input  logic  ld_low,	// Bits 8..15
	input  logic  ld_zmvc,	// Bits 0..3
	input  logic  leg_upd,	// L, E, G comparison result
	input  logic  ust_z,
	input  logic  ust_mc,
	input  logic  ust_v,
	input  logic  ust_y,
	input  logic  ust_x,
	input  logic  v_clr,
	input  logic  ovf,	// ALU overflow
	input  logic  zs,	// ALU result zero
	input  logic  s0,	// ALU sign
	input  logic  s_1,	// ALU extra bit
	input  logic  carry,
	input  logic  aryt,	// Arithmetic compare
	output word_t r0
);

	flags_t flags;
	word_t  r0_nxt;

	always_comb begin
		flags = r0[0:8];

		// ALU updates, strob1 only
		if (strob1) begin
			if (ust_z) begin
				flags[FLAG_Z] = zs;
			end
			if (ust_mc) begin
				flags[FLAG_M] = s0;
				flags[FLAG_C] = carry;
			end
			if (ust_v && ovf) begin
				flags[FLAG_V] = 1'b1;	// Sticky until cleared
			end
			if (ust_y) begin
				flags[FLAG_Y] = s_1;
			end
			if (ust_x) begin
				flags[FLAG_X] = s0;
			end
		end
		if (v_clr) begin
			flags[FLAG_V] = 1'b0;	// Any cycle, beats the set
		end

		// Compare results
		if (leg_upd) begin
			flags[FLAG_E] = zs;
			flags[FLAG_L] = aryt ? s_1 : carry;
			flags[FLAG_G] = ~zs & (aryt ? ~s_1 : ~carry);
		end

		r0_nxt = {flags, r0[9:15]};

		// W loads override ALU updates bit by bit
		if (ld_zmvc) begin
			r0_nxt[0:3] = w[0:3];
		end
		if (ld_low) begin
			r0_nxt[8:15] = w[8:15];	// User mode keeps Z..Y
		end
		if (ld_all) begin
			r0_nxt = w;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || zer) begin
			r0 <= '0;
		end else begin
			r0 <= r0_nxt;
		end
	end

endmodule

// File: design/pr_sys_regs.sv
// System registers RB, NB, Q, BS and system bus driver outputs
`timescale 1ns/1ps

module pr_sys_regs import pr_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  word_t w,
	input  logic  w_bar,	// W to NB, BS, Q
	input  logic  strob1,
	input  logic  clm,	// Master clear
	input  logic  zer_sp,
	input  logic  w_rba,	// RB[10:15]
	input  logic  w_rbb,	// RB[4:9]
	input  logic  w_rbc,	// RB[0:3]
	input  logic  bar_nb,	// NB onto system bus
	input  logic  q_nb,
	input  logic  bp_nb,
	input  logic  pn_nb,
	input  logic  rpn,
	output word_t rb,
	output nb_t   nb,
	output logic  q,	// User mode
	output logic  bs,
	output logic  zer,	// Clears Q and R0
	output nb_t   dnb,
	output logic  dqb,
	output logic  dpn,
	output logic  zgpn
);

	logic ld_bar;

	assign zer = clm | zer_sp;
	assign ld_bar = w_bar & strob1;

	// NB, BS, Q; clears win over load
	always_ff @(posedge clk) begin
		if (rst) begin
			nb <= '0;
			bs <= 1'b0;
			q <= 1'b0;
		end else begin
			if (ld_bar) begin
				nb <= w[12:15];
				bs <= w[11];
				q <= w[10];
			end
			if (clm) begin
				nb <= '0;
				bs <= 1'b0;
			end
			if (zer) begin
				q <= 1'b0;
			end
		end
	end

	// RB loaded in three fields from the low W bits
	always_ff @(posedge clk) begin
		if (rst) begin
			rb <= '0;
		end else begin
			if (w_rba) rb[10:15] <= w[10:15];
			if (w_rbb) rb[4:9] <= w[10:15];
			if (w_rbc) rb[0:3] <= w[12:15];
		end
	end

	assign dnb = bar_nb ? nb : nb_t'(0);
	assign dqb = q & q_nb;
	// Processor number seen by the other CPU
	assign dpn = ((bs ^ CPU_NUMBER) & bp_nb) | (CPU_NUMBER & pn_nb);
	assign zgpn = rpn ^ CPU_NUMBER;

endmodule

// File: design/pr_ki_mux.sv
// KI bus source multiplexer with status word packing
`timescale 1ns/1ps

module pr_ki_mux import pr_pkg::*; (
	input  logic  kia,	// Select high bit
	input  logic  kib,	// Select low bit
	input  word_t rz,
	input  word_t zp,
	input  rs_t   rs,
	input  logic  q,
	input  logic  bs,
	input  nb_t   nb,
	input  word_t rb,
	output word_t ki
);

	ki_sel_t sel;
	word_t   sr;

	assign sel = {kia, kib};
	assign sr = {rs, q, bs, nb};	// Status word, 10+1+1+4

	always_comb begin
		case (sel)
			KI_RZ:   ki = rz;
			KI_SR:   ki = sr;
			KI_RB:   ki = rb;
			default: ki = zp;	// KI_ZP
		endcase
	end

endmodule

// File: design/pr_unit.sv
// Register unit top level: control decode, user registers, R0, system registers, KI and L buses
`timescale 1ns/1ps

module pr_unit import pr_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// Register access
	input  logic      strob1,
	input  logic      strob2,
	input  logic      as2,
	input  logic      w_r,
	input  logic      lpc,
	input  logic      rpc,
	input  logic      wa,
	input  logic      blr,
	input  reg_addr_t addr,
	input  word_t     w,
	output word_t     l,
	// Flag control and ALU results
	input  logic      ustr0_fp,
	input  logic      ust_leg,
	input  logic      ust_z,
	input  logic      ust_mc,
	input  logic      ust_v,
	input  logic      ust_y,
	input  logic      ust_x,
	input  logic      v_clr,
	input  logic      ovf,
	input  logic      zs,
	input  logic      s0,
	input  logic      s_1,
	input  logic      carry,
	input  logic      aryt,
	// System registers and bus drivers
	input  logic      w_bar,
	input  logic      clm,
	input  logic      zer_sp,
	input  logic      w_rba,
	input  logic      w_rbb,
	input  logic      w_rbc,
	input  logic      bar_nb,
	input  logic      q_nb,
	input  logic      bp_nb,
	input  logic      pn_nb,
	input  logic      rpn,
	output word_t     rb,
	output nb_t       nb,
	output logic      q,
	output logic      bs,
	output logic      zer,
	output nb_t       dnb,
	output logic      dqb,
	output logic      dpn,
	output logic      zgpn,
	// KI bus
	input  logic      kia,
	input  logic      kib,
	input  word_t     rz,
	input  word_t     zp,
	input  rs_t       rs,
	output word_t     ki
);

	logic   ureg_we;
	logic   r0_ld_all;
	logic   r0_ld_low;
	logic   r0_ld_zmvc;
	logic   leg_upd;
	l_sel_t l_sel;
	word_t  ureg_rd;	// Addressed R1..R7
	word_t  r0;

	pr_ctrl i_pr_ctrl (
		.clk       (clk),
		.rst       (rst),
		.strob1    (strob1),
		.strob2    (strob2),
		.as2       (as2),
		.w_r       (w_r),
		.lpc       (lpc),
		.rpc       (rpc),
		.wa        (wa),
		.blr       (blr),
		.ustr0_fp  (ustr0_fp),
		.ust_leg   (ust_leg),
		.addr      (addr),
		.q         (q),
		.ureg_we   (ureg_we),
		.r0_ld_all (r0_ld_all),
		.r0_ld_low (r0_ld_low),
		.r0_ld_zmvc(r0_ld_zmvc),
		.leg_upd   (leg_upd),
		.l_sel     (l_sel)
	);

	pr_user_regs i_pr_user_regs (
		.clk (clk),
		.rst (rst),
		.we  (ureg_we),
		.addr(addr),
		.w   (w),
		.rd  (ureg_rd)
	);

	pr_r0_flags i_pr_r0_flags (
		.clk    (clk),
		.rst    (rst),
		.zer    (zer),
		.strob1 (strob1),
		.w      (w),
		.ld_all (r0_ld_all),
		.ld_low (r0_ld_low),
		.ld_zmvc(r0_ld_zmvc),
		.leg_upd(leg_upd),
		.ust_z  (ust_z),
		.ust_mc (ust_mc),
		.ust_v  (ust_v),
		.ust_y  (ust_y),
		.ust_x  (ust_x),
		.v_clr  (v_clr),
		.ovf    (ovf),
		.zs     (zs),
		.s0     (s0),
		.s_1    (s_1),
		.carry  (carry),
		.aryt   (aryt),
		.r0     (r0)
	);

	pr_sys_regs i_pr_sys_regs (
		.clk   (clk),
		.rst   (rst),
		.w     (w),
		.w_bar (w_bar),
		.strob1(strob1),
		.clm   (clm),
		.zer_sp(zer_sp),
		.w_rba (w_rba),
		.w_rbb (w_rbb),
		.w_rbc (w_rbc),
		.bar_nb(bar_nb),
		.q_nb  (q_nb),
		.bp_nb (bp_nb),
		.pn_nb (pn_nb),
		.rpn   (rpn),
		.rb    (rb),
		.nb    (nb),
		.q     (q),
		.bs    (bs),
		.zer   (zer),
		.dnb   (dnb),
		.dqb   (dqb),
		.dpn   (dpn),
		.zgpn  (zgpn)
	);

	pr_ki_mux i_pr_ki_mux (
		.kia(kia),
		.kib(kib),
		.rz (rz),
		.zp (zp),
		.rs (rs),
		.q  (q),
		.bs (bs),
		.nb (nb),
		.rb (rb),
		.ki (ki)
	);

	// L bus
	always_comb begin
		case (l_sel)
			L_R0_HI: l = {8'd0, r0[0:7]};	// Flags shifted into low byte
			L_R0:    l = r0;
			default: l = ureg_rd;
		endcase
	end

endmodule

// File: testbench/pr_unit_tb.sv
// Register unit testbench with clock, reset, reference model, LFSR stimulus, assertions and timeout
`timescale 1ns/1ps

module pr_unit_tb import pr_pkg::*; ();

	localparam int MAX_CYCLES = 2000;	// Roughly four times the ~500 stimulus cycles
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic clk = 1'b0;
	logic rst;
	logic strob1, strob2, as2, w_r, lpc, rpc, wa, blr;
	logic ustr0_fp, ust_leg, ust_z, ust_mc, ust_v, ust_y, ust_x, v_clr;
	logic ovf, zs, s0, s_1, carry, aryt;
	logic w_bar, clm, zer_sp, w_rba, w_rbb, w_rbc;
	logic bar_nb, q_nb, bp_nb, pn_nb, rpn, kia, kib;
	reg_addr_t addr;
	word_t w, rz, zp;
	rs_t rs;
	word_t l, rb, ki;
	nb_t nb, dnb;
	logic q, bs, zer, dqb, dpn, zgpn;

	// Reference model state committed on the falling edge after each clock
	word_t m_regs [1:7];
	word_t m_r0 = '0;
	word_t m_rb = '0;
	nb_t m_nb = '0;
	logic m_q = 1'b0;
	logic m_bs = 1'b0;
	logic m_last_a = 1'b0;	// strob_a seen in the previous cycle

	nb_t exp_dnb;
	logic exp_dqb, exp_dpn;
	word_t exp_ki;
	logic [31:0] lfsr = 32'h3d1f;
	int cycles = 0;

	pr_unit i_pr_unit (.*);

	always #10 clk = ~clk;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rnd(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic fail(input string msg);
		$display("Fail @ %0t ns: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// Expected L bus from the model
	function automatic word_t exp_l();
		if (blr) return {8'd0, m_r0[0:7]};
		if (addr == reg_addr_t'(0) || (rpc && wa)) return m_r0;
		return m_regs[addr];
	endfunction

	always_comb begin
		exp_dnb = '0;
		exp_dqb = 1'b0;
		exp_dpn = 1'b0;
		if (bar_nb) exp_dnb = m_nb;
		if (q_nb) exp_dqb = m_q;
		if (bp_nb && m_bs != CPU_NUMBER) exp_dpn = 1'b1;	// BS seen inverted on CPU 1
		if (pn_nb && CPU_NUMBER) exp_dpn = 1'b1;
		case ({kia, kib})
			KI_RZ:   exp_ki = rz;
			KI_SR:   exp_ki = {rs, m_q, m_bs, m_nb};	// Packed status word
			KI_RB:   exp_ki = m_rb;
			default: exp_ki = zp;
		endcase
	end

	// Sampled at the rising edge when model and inputs have settled
	assert property (@(posedge clk) disable iff (rst) q == m_q && bs == m_bs && nb == m_nb)
		else fail("q, bs or nb differ from the model");
	assert property (@(posedge clk) disable iff (rst) rb == m_rb)
		else fail("rb differs from the model");
	assert property (@(posedge clk) disable iff (rst) dnb == exp_dnb && dqb == exp_dqb)
		else fail("dnb or dqb wrong");
	assert property (@(posedge clk) disable iff (rst) dpn == exp_dpn)
		else fail("dpn wrong");
	assert property (@(posedge clk) disable iff (rst) zgpn == (rpn != CPU_NUMBER))
		else fail("zgpn wrong");
	assert property (@(posedge clk) disable iff (rst) zer == (clm | zer_sp))
		else fail("zer wrong");
	assert property (@(posedge clk) disable iff (rst) ki == exp_ki)
		else fail("ki does not match the selected source");

	task automatic idle();
		{strob1, strob2, as2, w_r, lpc, rpc, wa, blr} = '0;
		{ustr0_fp, ust_leg, ust_z, ust_mc, ust_v, ust_y, ust_x, v_clr} = '0;
		{ovf, zs, s0, s_1, carry, aryt} = '0;
		{w_bar, clm, zer_sp, w_rba, w_rbb, w_rbc} = '0;
		{bar_nb, q_nb, bp_nb, pn_nb, rpn, kia, kib} = '0;
		addr = '0;
		w = '0;
		rz = '0;
		zp = '0;
		rs = '0;
	endtask

	// Works out the model next state and runs one clock
	task automatic tick();
		logic sa, sb, wr, a0, q_n, bs_n, ureg_wr;
		word_t r0_n, rb_n, uw;
		nb_t nb_n;
		reg_addr_t ua;
		sa = strob1 & ~as2;
		sb = strob2 & as2 & ~m_last_a;	// Overlapping strob_b ignored
		wr = w_r & (sa | sb);
		a0 = (addr == reg_addr_t'(0));
		ureg_wr = wr & ~a0;
		ua = addr;
		uw = w;
		r0_n = m_r0;
		if (strob1) begin
			if (ust_z) r0_n[FLAG_Z] = zs;
			if (ust_mc) begin
				r0_n[FLAG_M] = s0;
				r0_n[FLAG_C] = carry;
			end
			if (ust_v && ovf) r0_n[FLAG_V] = 1'b1;
			if (ust_y) r0_n[FLAG_Y] = s_1;
			if (ust_x) r0_n[FLAG_X] = s0;
		end
		if (v_clr) r0_n[FLAG_V] = 1'b0;
		if (strob2 && ust_leg) begin	// Compare result
			r0_n[FLAG_E] = zs;
			r0_n[FLAG_L] = aryt ? s_1 : carry;
			r0_n[FLAG_G] = ~zs & (aryt ? ~s_1 : ~carry);
		end
		if (AWP_PRESENT && ustr0_fp && sa) r0_n[0:3] = w[0:3];
		if (wr && a0 && m_q) r0_n[8:15] = w[8:15];	// User mode
		if ((lpc && sa) || (wr && a0 && !m_q)) r0_n = w;
		if (clm || zer_sp) r0_n = '0;
		q_n = m_q;
		bs_n = m_bs;
		nb_n = m_nb;
		if (w_bar && strob1) begin
			nb_n = w[12:15];
			bs_n = w[11];
			q_n = w[10];
		end
		if (clm) begin
			nb_n = '0;
			bs_n = 1'b0;
		end
		if (clm || zer_sp) q_n = 1'b0;
		rb_n = m_rb;
		if (w_rba) rb_n[10:15] = w[10:15];
		if (w_rbb) rb_n[4:9] = w[10:15];
		if (w_rbc) rb_n[0:3] = w[12:15];
		@(posedge clk);
		@(negedge clk);
		if (ureg_wr) m_regs[ua] = uw;
		m_r0 = r0_n;
		m_rb = rb_n;
		m_nb = nb_n;
		m_q = q_n;
		m_bs = bs_n;
		m_last_a = sa;
	endtask

	// Checks l once the inputs settle, then a readback clock that writes nothing
	task automatic check_l(input string what);
		#1;
		assert (l === exp_l()) else fail($sformatf("%s: l=%h expected %h", what, l, exp_l()));
		tick();
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		for (int i = 1; i <= 7; i++) m_regs[i] = '0;
		rst = 1'b1;
		idle();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Reset state with drivers enabled and nothing to drive
		{bar_nb, q_nb, bp_nb, pn_nb} = 4'hf;
		check_l("R0 after reset");
		assert ({dnb, dqb, dpn} === 6'b0) else fail("driver outputs active after reset");

		// R1..R7 through both strobe phases
		for (int p = 0; p < 2; p++) begin
			for (int r = 1; r <= 7; r++) begin
				idle();
				addr = reg_addr_t'(r);
				w = word_t'(rnd(16));
				w_r = 1'b1;
				as2 = p[0];
				strob1 = ~p[0];
				strob2 = p[0];
				tick();
				idle();
				addr = reg_addr_t'(r);
				check_l("user register readback");
			end
		end

		// strob_b right behind a strob_a is the same access and writes nothing
		idle();
		addr = reg_addr_t'(1);
		w = word_t'(rnd(16));
		w_r = 1'b1;
		strob1 = 1'b1;
		tick();
		idle();
		addr = reg_addr_t'(2);
		w = word_t'(rnd(16));
		w_r = 1'b1;
		as2 = 1'b1;
		strob2 = 1'b1;
		tick();
		idle();
		addr = reg_addr_t'(2);
		check_l("overlapping strob_b rejected");

		// R0 writes in system and user mode
		idle();
		w = word_t'(rnd(16));
		w_r = 1'b1;
		strob1 = 1'b1;
		tick();
		idle();
		check_l("R0 full write, system mode");
		w = word_t'(rnd(16));
		w[10] = 1'b1;	// Sets Q
		w_bar = 1'b1;
		strob1 = 1'b1;
		tick();
		idle();
		w = word_t'(rnd(16));
		w_r = 1'b1;
		strob1 = 1'b1;
		tick();
		idle();
		check_l("R0 low byte write, user mode");
		w = word_t'(rnd(16));
		lpc = 1'b1;
		strob1 = 1'b1;
		tick();
		idle();
		check_l("R0 load by LPC");
		blr = 1'b1;
		check_l("R0 high byte on L");

		// ALU flag rules read back via rpc and wa
		for (int i = 0; i < 150; i++) begin
			idle();
			{ust_z, ust_mc, ust_v, ust_y, ust_x, ust_leg} = 6'(rnd(6));
			{zs, s0, s_1, carry, aryt, ovf} = 6'(rnd(6));
			v_clr = (rnd(2) == 0);
			{strob1, strob2} = 2'(rnd(2));
			tick();
			idle();
			addr = reg_addr_t'(rnd(3));
			rpc = 1'b1;
			wa = 1'b1;
			check_l("R0 flags after ALU update");
		end

		// NB, BS and Q loads and clears with driver outputs
		for (int i = 0; i < 40; i++) begin
			idle();
			w = word_t'(rnd(16));
			{w_bar, strob1, bar_nb, q_nb, bp_nb, pn_nb, rpn} = 7'(rnd(7));
			lpc = 1'b1;	// Reloads R0 so each clear has something to clear
			clm = (rnd(3) == 0);
			zer_sp = (rnd(3) == 0);
			tick();
			idle();
			check_l("R0 after system register cycle");
		end

		// RB field loads and KI select
		for (int i = 0; i < 40; i++) begin
			idle();
			w = word_t'(rnd(16));
			{w_rba, w_rbb, w_rbc, kia, kib} = 5'(rnd(5));
			rz = word_t'(rnd(16));
			zp = word_t'(rnd(16));
			rs = rs_t'(rnd(10));
			w_bar = 1'(rnd(1));
			strob1 = w_bar;
			tick();
		end

		// Co-processor ZMVC load
		for (int i = 0; i < 20; i++) begin
			idle();
			w = word_t'(rnd(16));
			ustr0_fp = 1'b1;
			strob1 = 1'b1;
			tick();
			idle();
			check_l("ZMVC load from W");
		end

		idle();
		repeat (2) @(negedge clk);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: sim.f
design/pr_pkg.sv
design/pr_ctrl.sv
design/pr_user_regs.sv
design/pr_r0_flags.sv
design/pr_sys_regs.sv
design/pr_ki_mux.sv
design/pr_unit.sv
testbench/pr_unit_tb.sv

// File: Bender.yml
package:
  name: pr_unit

sources:
  - design/pr_pkg.sv
  - design/pr_ctrl.sv
  - design/pr_user_regs.sv
  - design/pr_r0_flags.sv
  - design/pr_sys_regs.sv
  - design/pr_ki_mux.sv
  - design/pr_unit.sv
  - target: simulation
    files:
      - testbench/pr_unit_tb.sv
